// ==== src/kaboom_pkg.sv ====
package kaboom_pkg;

	////////////////////////////////////////////////////////////////////////////
	// raster geometry, 640x480 at 60 Hz
	////////////////////////////////////////////////////////////////////////////
	localparam int H_ACTIVE     = 640;
	localparam int H_TOTAL      = 800;
	localparam int H_SYNC_START = 656;  // front porch 16
	localparam int H_SYNC_END   = 752;  // sync 96 wide
	localparam int V_ACTIVE     = 480;
	localparam int V_TOTAL      = 525;
	localparam int V_SYNC_START = 490;
	localparam int V_SYNC_END   = 492;  // two lines of sync

	localparam int PIX_DIV = 4;  // system clocks per pixel step
	localparam int COORD_W = 11; // wide enough for 0..799

	////////////////////////////////////////////////////////////////////////////
	// objects and rows
	////////////////////////////////////////////////////////////////////////////
	localparam int BOMBER_W   = 64;
	localparam int PADDLE_W   = 84;
	localparam int BOMB_W     = 22;
	localparam int BOMB_H     = 32;
	localparam int BOMB_X_OFS = 21; // bomb drops from under the bomber's middle

	localparam int SCORE_BAR_BOT = 19;  // black strip at the very top
	localparam int SKY_TOP       = 20;
	localparam int SKY_BOT       = 107; // bomber walks inside the sky band
	localparam int LAUNCH_TOP    = 108; // first row of a fresh bomb

	localparam int NUM_PAD_ROWS               = 3;
	localparam int PAD_ROW_TOP [NUM_PAD_ROWS] = '{410, 435, 460};
	localparam int PAD_ROW_H                  = 16;

	localparam int CATCH_BOT = 399; // bomb bottom on the catch line
	localparam int MISS_BOT  = 479; // bomb bottom at the screen floor

	localparam int TITLE_BOMB_X = 310; // centred title bomb
	localparam int TITLE_BOMB_Y = 200;

	localparam int NUM_BOMBS  = 5;
	localparam int LAUNCH_GAP = 50; // rows between staggered launches
	localparam int SCORE_W    = 10;

	////////////////////////////////////////////////////////////////////////////
	// colours, rrr ggg bb
	////////////////////////////////////////////////////////////////////////////
	localparam logic [2:0] COLOR_BOMB_R = 3'd1; // near black
	localparam logic [2:0] COLOR_BOMB_G = 3'd1;
	localparam logic [1:0] COLOR_BOMB_B = 2'd1;

	localparam logic [2:0] COLOR_BOMBER_R = 3'd7;
	localparam logic [2:0] COLOR_BOMBER_G = 3'd6;
	localparam logic [1:0] COLOR_BOMBER_B = 2'd2;

	localparam logic [2:0] COLOR_PADDLE_R = 3'd6;
	localparam logic [2:0] COLOR_PADDLE_G = 3'd1;
	localparam logic [1:0] COLOR_PADDLE_B = 2'd0;

	localparam logic [2:0] COLOR_SKY_R = 3'd2;
	localparam logic [2:0] COLOR_SKY_G = 3'd3;
	localparam logic [1:0] COLOR_SKY_B = 2'd0;

	localparam logic [2:0] COLOR_FIELD_R = 3'd0;
	localparam logic [2:0] COLOR_FIELD_G = 3'd5;
	localparam logic [1:0] COLOR_FIELD_B = 2'd3;

	localparam logic [2:0] COLOR_TITLE_BOMB_R = 3'd7; // bright red on black
	localparam logic [2:0] COLOR_TITLE_BOMB_G = 3'd0;
	localparam logic [1:0] COLOR_TITLE_BOMB_B = 2'd0;

	localparam int TICK_DIV_DEFAULT = 524288; // 2^19 clocks, about 95 Hz at 50 MHz

endpackage

// ==== src/vga_timing.sv ====
module vga_timing import kaboom_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	output logic               pix_en,    // one clock in every PIX_DIV
	output logic [COORD_W-1:0] hcount,
	output logic [COORD_W-1:0] vcount,
	output logic               hsync_raw, // low inside the sync window
	output logic               vsync_raw,
	output logic               active     // visible 640x480 area
);

	logic [1:0] div_cnt; // position inside the pixel step
	logic       h_last;  // last pixel of a line
	logic       v_last;  // last line of a frame

	////////////////////////////////////////////////////////////////////////////
	// pixel strobe
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
		end else if (div_cnt == 2'(PIX_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pix_en = (div_cnt == 2'(PIX_DIV - 1));

	////////////////////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////////////////////
	assign h_last = (hcount == COORD_W'(H_TOTAL - 1));
	assign v_last = (vcount == COORD_W'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (pix_en) begin
			if (h_last) begin
				hcount <= '0;
				// next line only at the end of this one
				if (v_last) begin
					vcount <= '0;
				end else begin
					vcount <= vcount + 1'b1;
				end
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

	// negative syncs, straight from the counters
	assign hsync_raw = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_END));
	assign vsync_raw = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_END));
	assign active    = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);

endmodule

// ==== src/player_motion.sv ====
module player_motion import kaboom_pkg::*; #(
	parameter int TICK_DIV = TICK_DIV_DEFAULT // clocks per game tick
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               bomber_right,
	input  logic               bomber_left,
	input  logic               pad_right,
	input  logic               pad_left,
	output logic               playing,  // low on the title screen
	output logic               tick,     // one clock per game step
	output logic [COORD_W-1:0] bomber_x, // left edge
	output logic [COORD_W-1:0] paddle_x  // left edge
);

	localparam int TCW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [TCW-1:0] tick_cnt;

	// one pixel toward the pressed side, held inside the screen
	function automatic logic [COORD_W-1:0] step_x(
		input logic [COORD_W-1:0] x,
		input logic               right,
		input logic               left,
		input int                 w
	);
		logic [COORD_W-1:0] nx;
		nx = x;
		if (right && (x < H_ACTIVE - w)) begin // right edge still below 639
			nx = x + 1'b1;
		end else if (left && (x != '0)) begin
			nx = x - 1'b1;
		end
		return nx;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// title gate and game tick
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			playing <= 1'b0;
		end else if (start) begin
			playing <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge clk) begin
		if (rst || !playing) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else begin
			tick <= (tick_cnt == TCW'(TICK_DIV - 1));
			if (tick_cnt == TCW'(TICK_DIV - 1)) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// movement, right wins over left
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			bomber_x <= '0;
			paddle_x <= '0;
		end else if (tick) begin
			bomber_x <= step_x(bomber_x, bomber_right, bomber_left, BOMBER_W);
			paddle_x <= step_x(paddle_x, pad_right, pad_left, PADDLE_W);
		end
	end

endmodule

// ==== src/bomb_drop.sv ====
module bomb_drop import kaboom_pkg::*; (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           playing,
	input  logic                           tick,
	input  logic [COORD_W-1:0]             bomber_x,
	input  logic [COORD_W-1:0]             paddle_x,
	output logic [NUM_BOMBS-1:0]           bomb_live,
	output logic [NUM_BOMBS*COORD_W-1:0]   bomb_x,   // slot k at k*COORD_W
	output logic [NUM_BOMBS*COORD_W-1:0]   bomb_y,   // top row of each bomb
	output logic [SCORE_W-1:0]             score
);

	localparam int CW = $clog2(NUM_BOMBS + 1); // catches per tick

	logic [COORD_W-1:0]   slot_x [NUM_BOMBS];
	logic [COORD_W-1:0]   slot_y [NUM_BOMBS];
	logic [NUM_BOMBS-1:0] catch_v;  // landed on the paddle this tick
	logic [NUM_BOMBS-1:0] miss_v;   // hit the floor this tick
	logic [NUM_BOMBS-1:0] launch_v; // idle slot allowed to start
	logic [CW-1:0]        catch_sum;
	logic [COORD_W-1:0]   launch_x;

	assign launch_x = bomber_x + COORD_W'(BOMB_X_OFS);

	////////////////////////////////////////////////////////////////////////////
	// per slot decode
	////////////////////////////////////////////////////////////////////////////
	for (genvar k = 0; k < NUM_BOMBS; k++) begin : g_slot
		logic [COORD_W-1:0] bot;  // bottom row of the bomb
		logic               over; // bomb and paddle spans overlap

		assign bot  = slot_y[k] + COORD_W'(BOMB_H - 1);
		assign over = (slot_x[k] <= paddle_x + COORD_W'(PADDLE_W - 1))
			&& (paddle_x <= slot_x[k] + COORD_W'(BOMB_W - 1));

		assign catch_v[k] = bomb_live[k] && (bot == COORD_W'(CATCH_BOT)) && over;
		assign miss_v[k]  = bomb_live[k] && (bot == COORD_W'(MISS_BOT));

		if (k == 0) begin : g_first
			assign launch_v[k] = !bomb_live[k]; // leader goes whenever free
		end else begin : g_next
			// wait for the slot ahead to clear the gap
			assign launch_v[k] = !bomb_live[k] && bomb_live[k-1]
				&& (slot_y[k-1] == COORD_W'(LAUNCH_TOP + LAUNCH_GAP));
		end

		assign bomb_x[k*COORD_W +: COORD_W] = slot_x[k];
		assign bomb_y[k*COORD_W +: COORD_W] = slot_y[k];
	end

	// several bombs may land on one tick
	always_comb begin
		catch_sum = '0;
		for (int k = 0; k < NUM_BOMBS; k++) begin
			catch_sum = catch_sum + CW'(catch_v[k]);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// slot state
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst || !playing) begin
			bomb_live <= '0;
		end else if (tick) begin
			bomb_live <= (bomb_live & ~(catch_v | miss_v)) | launch_v;
		end
	end

	// positions, only meaningful while live
	always_ff @(posedge clk) begin
		if (tick) begin
			for (int k = 0; k < NUM_BOMBS; k++) begin
				if (launch_v[k]) begin
					slot_x[k] <= launch_x;
					slot_y[k] <= COORD_W'(LAUNCH_TOP);
				end else if (bomb_live[k]) begin
					slot_y[k] <= slot_y[k] + 1'b1; // one line per tick
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			score <= '0;
		end else if (tick) begin
			score <= score + SCORE_W'(catch_sum); // wraps at 1024
		end
	end

endmodule

// ==== src/pixel_color.sv ====
module pixel_color import kaboom_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         pix_en,
	input  logic                         active,
	input  logic                         playing,
	input  logic [COORD_W-1:0]           hcount,
	input  logic [COORD_W-1:0]           vcount,
	input  logic [NUM_BOMBS-1:0]         bomb_live,
	input  logic [NUM_BOMBS*COORD_W-1:0] bomb_x,
	input  logic [NUM_BOMBS*COORD_W-1:0] bomb_y,
	input  logic [COORD_W-1:0]           bomber_x,
	input  logic [COORD_W-1:0]           paddle_x,
	output logic [2:0]                   red,
	output logic [2:0]                   green,
	output logic [1:0]                   blue
);

	logic [NUM_BOMBS-1:0]    bomb_hit;
	logic [NUM_PAD_ROWS-1:0] pad_row;    // raster inside a paddle row
	logic                    bomber_hit;
	logic                    paddle_hit;
	logic                    sky_hit;
	logic                    field_hit;
	logic                    title_hit;
	logic [2:0]              nxt_r;
	logic [2:0]              nxt_g;
	logic [1:0]              nxt_b;

	////////////////////////////////////////////////////////////////////////////
	// region tests on the current raster position
	////////////////////////////////////////////////////////////////////////////
	for (genvar k = 0; k < NUM_BOMBS; k++) begin : g_bomb
		logic [COORD_W-1:0] bx;
		logic [COORD_W-1:0] by;

		assign bx = bomb_x[k*COORD_W +: COORD_W];
		assign by = bomb_y[k*COORD_W +: COORD_W];
		assign bomb_hit[k] = bomb_live[k]
			&& (hcount >= bx) && (hcount < bx + COORD_W'(BOMB_W))
			&& (vcount >= by) && (vcount < by + COORD_W'(BOMB_H));
	end

	for (genvar r = 0; r < NUM_PAD_ROWS; r++) begin : g_row
		assign pad_row[r] = (vcount >= PAD_ROW_TOP[r])
			&& (vcount < PAD_ROW_TOP[r] + PAD_ROW_H);
	end

	assign bomber_hit = (hcount >= bomber_x) && (hcount < bomber_x + COORD_W'(BOMBER_W))
		&& (vcount >= SKY_TOP) && (vcount <= SKY_BOT);
	assign paddle_hit = (hcount >= paddle_x) && (hcount < paddle_x + COORD_W'(PADDLE_W))
		&& (|pad_row); // same x on all three rows
	assign sky_hit    = (vcount > SCORE_BAR_BOT) && (vcount <= SKY_BOT);
	assign field_hit  = (vcount >= LAUNCH_TOP) && (vcount < V_ACTIVE);
	assign title_hit  = (hcount >= TITLE_BOMB_X) && (hcount < TITLE_BOMB_X + BOMB_W)
		&& (vcount >= TITLE_BOMB_Y) && (vcount < TITLE_BOMB_Y + BOMB_H);

	////////////////////////////////////////////////////////////////////////////
	// colour priority
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		nxt_r = '0; // blanking, score bar and title background
		nxt_g = '0;
		nxt_b = '0;
		if (!active) begin
			nxt_r = '0;
		end else if (!playing) begin
			if (title_hit) begin
				nxt_r = COLOR_TITLE_BOMB_R;
				nxt_g = COLOR_TITLE_BOMB_G;
				nxt_b = COLOR_TITLE_BOMB_B;
			end
		end else if (|bomb_hit) begin // bombs over everything
			nxt_r = COLOR_BOMB_R;
			nxt_g = COLOR_BOMB_G;
			nxt_b = COLOR_BOMB_B;
		end else if (bomber_hit) begin
			nxt_r = COLOR_BOMBER_R;
			nxt_g = COLOR_BOMBER_G;
			nxt_b = COLOR_BOMBER_B;
		end else if (paddle_hit) begin
			nxt_r = COLOR_PADDLE_R;
			nxt_g = COLOR_PADDLE_G;
			nxt_b = COLOR_PADDLE_B;
		end else if (sky_hit) begin
			nxt_r = COLOR_SKY_R;
			nxt_g = COLOR_SKY_G;
			nxt_b = COLOR_SKY_B;
		end else if (field_hit) begin
			nxt_r = COLOR_FIELD_R;
			nxt_g = COLOR_FIELD_G;
			nxt_b = COLOR_FIELD_B;
		end
	end

	// one pixel step behind the counters
	always_ff @(posedge clk) begin
		if (rst) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else if (pix_en) begin
			red   <= nxt_r;
			green <= nxt_g;
			blue  <= nxt_b;
		end
	end

endmodule

// ==== src/kaboom_top.sv ====
module kaboom_top import kaboom_pkg::*; #(
	parameter int TICK_DIV = TICK_DIV_DEFAULT // game speed
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               bomber_right,
	input  logic               bomber_left,
	input  logic               pad_right,
	input  logic               pad_left,
	output logic [2:0]         red,
	output logic [2:0]         green,
	output logic [1:0]         blue,
	output logic               hsync,
	output logic               vsync,
	output logic [SCORE_W-1:0] score,
	output logic               playing
);

	logic                         pix_en;
	logic [COORD_W-1:0]           hcount;
	logic [COORD_W-1:0]           vcount;
	logic                         hsync_raw;
	logic                         vsync_raw;
	logic                         active;
	logic                         tick;
	logic [COORD_W-1:0]           bomber_x;
	logic [COORD_W-1:0]           paddle_x;
	logic [NUM_BOMBS-1:0]         bomb_live;
	logic [NUM_BOMBS*COORD_W-1:0] bomb_x;
	logic [NUM_BOMBS*COORD_W-1:0] bomb_y;

	vga_timing u_timing (
		.clk, .rst, .pix_en, .hcount, .vcount, .hsync_raw, .vsync_raw, .active
	);

	player_motion #(.TICK_DIV(TICK_DIV)) u_motion (
		.clk, .rst, .start, .bomber_right, .bomber_left, .pad_right, .pad_left,
		.playing, .tick, .bomber_x, .paddle_x
	);

	bomb_drop u_bombs (
		.clk, .rst, .playing, .tick, .bomber_x, .paddle_x,
		.bomb_live, .bomb_x, .bomb_y, .score
	);

	pixel_color u_color (
		.clk, .rst, .pix_en, .active, .playing, .hcount, .vcount,
		.bomb_live, .bomb_x, .bomb_y, .bomber_x, .paddle_x,
		.red, .green, .blue
	);

	////////////////////////////////////////////////////////////////////////////
	// syncs take the same one step as the colour register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			hsync <= 1'b1; // idle high
			vsync <= 1'b1;
		end else if (pix_en) begin
			hsync <= hsync_raw;
			vsync <= vsync_raw;
		end
	end

endmodule

// ==== verification/kaboom_properties.sv ====
module kaboom_properties import kaboom_pkg::*; (
	input logic               clk,
	input logic               rst,
	input logic               pix_en,
	input logic               hsync,
	input logic               vsync,
	input logic               playing,
	input logic               tick,
	input logic [2:0]         red,
	input logic [2:0]         green,
	input logic [1:0]         blue,
	input logic [SCORE_W-1:0] score
);

	localparam int H_LOW_CLKS  = (H_SYNC_END - H_SYNC_START) * PIX_DIV; // 384
	localparam int H_LINE_CLKS = H_TOTAL * PIX_DIV;                     // 3200
	localparam int V_LOW_CLKS  = (V_SYNC_END - V_SYNC_START) * H_LINE_CLKS; // two lines

	int unsigned fail_count = 0; // failed assertions so far
	int unsigned low_len;        // clocks of the current hsync low
	int unsigned v_low_len;      // clocks of the current vsync low
	int unsigned since_fall;     // clocks since the last hsync fall
	logic        seen_fall;      // one full line needs a first edge
	logic        hsync_q;
	logic        vsync_q;
	logic        h_rise;
	logic        h_fall;
	logic        v_rise;

	////////////////////////////////////////////////////////////////////////////
	// sync edge bookkeeping
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			hsync_q    <= 1'b1;
			vsync_q    <= 1'b1;
			low_len    <= 0;
			v_low_len  <= 0;
			since_fall <= 0;
			seen_fall  <= 1'b0;
		end else begin
			hsync_q   <= hsync;
			vsync_q   <= vsync;
			low_len   <= hsync ? 0 : low_len + 1;
			v_low_len <= vsync ? 0 : v_low_len + 1;
			if (h_fall) begin
				since_fall <= 1;
				seen_fall  <= 1'b1;
			end else begin
				since_fall <= since_fall + 1;
			end
		end
	end

	assign h_rise = !hsync_q && hsync;
	assign h_fall = hsync_q && !hsync;
	assign v_rise = !vsync_q && vsync;

	a_hsync_low: assert property (@(posedge clk) disable iff (rst)
		h_rise |-> low_len == H_LOW_CLKS)
		else begin fail_count++; $error("hsync low pulse has the wrong length"); end
	a_hsync_period: assert property (@(posedge clk) disable iff (rst)
		(h_fall && seen_fall) |-> since_fall == H_LINE_CLKS)
		else begin fail_count++; $error("hsync falling edges are not one line apart"); end
	a_vsync_low: assert property (@(posedge clk) disable iff (rst)
		v_rise |-> v_low_len == V_LOW_CLKS)
		else begin fail_count++; $error("vsync low pulse is not two lines long"); end

	// colour is cleared by reset and moves only with the pixel strobe
	a_color_reset: assert property (@(posedge clk)
		rst |=> {red, green, blue} == '0)
		else begin fail_count++; $error("colour not cleared by reset"); end
	a_color_hold: assert property (@(posedge clk) disable iff (rst)
		!pix_en |=> $stable({red, green, blue}))
		else begin fail_count++; $error("colour changed without a pixel step"); end

	a_title_score: assert property (@(posedge clk) disable iff (rst)
		!playing |-> score == '0)
		else begin fail_count++; $error("score is not zero on the title screen"); end
	a_play_sticky: assert property (@(posedge clk) disable iff (rst)
		playing |=> playing)
		else begin fail_count++; $error("playing fell without a reset"); end
	a_score_hold: assert property (@(posedge clk) disable iff (rst)
		!(tick && playing) |=> $stable(score))
		else begin fail_count++; $error("score changed off a game tick"); end
	a_score_step: assert property (@(posedge clk) disable iff (rst)
		(tick && playing) |=> SCORE_W'(score - $past(score)) <= SCORE_W'(NUM_BOMBS))
		else begin fail_count++; $error("score jumped by more than the bomb count"); end

endmodule

bind kaboom_top kaboom_properties u_props (
	.clk(clk), .rst(rst), .pix_en(pix_en), .hsync(hsync), .vsync(vsync),
	.playing(playing), .tick(tick), .red(red), .green(green), .blue(blue),
	.score(score)
);

// ==== verification/kaboom_tb.sv ====
module kaboom_tb import kaboom_pkg::*; ();

	localparam int          TICK_DIV_TB = 64;                          // fast game tick
	localparam logic [31:0] SEED        = 32'h38e32f5d;
	localparam int          FRAME_CLKS  = H_TOTAL * V_TOTAL * PIX_DIV; // one full frame
	localparam int          PAD_MAX_X   = H_ACTIVE - PADDLE_W;         // right clamp, 556

	logic               clk;
	logic               rst;
	logic               start;
	logic               bomber_right;
	logic               bomber_left;
	logic               pad_right;
	logic               pad_left;
	logic [2:0]         red;
	logic [2:0]         green;
	logic [1:0]         blue;
	logic               hsync;
	logic               vsync;
	logic [SCORE_W-1:0] score;
	logic               playing;
	int                 tb_errors = 0;
	int                 timeouts  = 0;

	kaboom_top #(.TICK_DIV(TICK_DIV_TB)) dut0 (
		.clk, .rst, .start, .bomber_right, .bomber_left, .pad_right, .pad_left,
		.red, .green, .blue, .hsync, .vsync, .score, .playing
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // period 20
	end

	task automatic expect_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			tb_errors++;
			$display("Error %s: expected %h got %h", name, exp, got);
		end
	endtask

	// falling edges until bomber or paddle sits at x
	task automatic wait_object_x(input logic paddle, input int x, input int limit,
		input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (((paddle ? dut0.paddle_x : dut0.bomber_x) != x) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if ((paddle ? dut0.paddle_x : dut0.bomber_x) != x) begin
			timeouts++;
			$display("Timeout: %s never reached x %0d", what, x);
		end
	endtask

	task automatic wait_score(input int target, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while ((score < target) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (score < target) begin
			timeouts++;
			$display("Timeout: score stayed below %0d", target);
		end
	endtask

	// colour of raster position x,y shows one pixel step after it is presented
	task automatic check_pixel(input int x, input int y, input logic [2:0] r, g,
		input logic [1:0] b, input string region);
		int n;
		n = 0;
		@(negedge clk);
		while (!(dut0.pix_en && (dut0.hcount == x) && (dut0.vcount == y))
			&& (n < FRAME_CLKS)) begin
			@(negedge clk);
			n++;
		end
		if (n >= FRAME_CLKS) begin
			timeouts++;
			$display("Timeout: raster never reached %0d,%0d", x, y);
		end else begin
			@(negedge clk); // colour register loads on the edge in between
			expect_value({"red ", region}, red, r);
			expect_value({"green ", region}, green, g);
			expect_value({"blue ", region}, blue, b);
		end
	endtask

	initial begin
		int                 idle;
		int                 len;
		logic [SCORE_W-1:0] held;

		void'($urandom(SEED));
		rst          = 1'b1;
		start        = 1'b0;
		bomber_right = 1'b0;
		bomber_left  = 1'b0;
		pad_right    = 1'b0;
		pad_left     = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		////////////////////////////////////////////////////////////////////////////
		// title screen
		////////////////////////////////////////////////////////////////////////////
		@(negedge clk);
		expect_value("red", red, 0); // no pixel step yet
		expect_value("green", green, 0);
		expect_value("blue", blue, 0);
		check_pixel(TITLE_BOMB_X + 5, TITLE_BOMB_Y + 5, COLOR_TITLE_BOMB_R,
			COLOR_TITLE_BOMB_G, COLOR_TITLE_BOMB_B, "title bomb");
		check_pixel(TITLE_BOMB_X + 40, TITLE_BOMB_Y + 5, 3'd0, 3'd0, 2'd0, "title background");

		idle = $urandom_range(200, 20);
		repeat (idle) @(posedge clk);
		start <= 1'b1; // one clock pulse
		@(negedge clk);
		expect_value("playing", playing, 0);
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		expect_value("playing", playing, 1);

		////////////////////////////////////////////////////////////////////////////
		// catching with the paddle parked at x 0
		////////////////////////////////////////////////////////////////////////////
		for (int i = 0; i < 3; i++) begin
			len = $urandom_range(30, 1);
			@(posedge clk);
			bomber_right <= 1'b1;
			repeat (len * TICK_DIV_TB) @(posedge clk); // exactly len ticks
			bomber_right <= 1'b0;
			@(negedge clk);
			expect_value("bomber_x", dut0.bomber_x, len);
			@(posedge clk);
			bomber_left <= 1'b1;
			wait_object_x(1'b0, 0, (len + 2) * TICK_DIV_TB, "bomber");
			@(posedge clk);
			bomber_left <= 1'b0;
		end
		wait_score(3, 600 * TICK_DIV_TB);
		expect_value("score", score, 3); // staggered bombs land one at a time

		check_pixel(600, SCORE_BAR_BOT - 5, 3'd0, 3'd0, 2'd0, "score bar");
		check_pixel(600, SKY_TOP + 40, COLOR_SKY_R, COLOR_SKY_G, COLOR_SKY_B, "sky");
		check_pixel(600, 300, COLOR_FIELD_R, COLOR_FIELD_G, COLOR_FIELD_B, "field");
		check_pixel(10, PAD_ROW_TOP[0] + 5, COLOR_PADDLE_R, COLOR_PADDLE_G,
			COLOR_PADDLE_B, "paddle");

		////////////////////////////////////////////////////////////////////////////
		// missing with the paddle at the right edge
		////////////////////////////////////////////////////////////////////////////
		@(posedge clk);
		pad_right <= 1'b1;
		wait_object_x(1'b1, PAD_MAX_X, 700 * TICK_DIV_TB, "paddle");
		repeat (10 * TICK_DIV_TB) @(posedge clk); // keep pushing into the clamp
		pad_right <= 1'b0;
		@(negedge clk);
		expect_value("paddle_x", dut0.paddle_x, PAD_MAX_X);
		repeat (500 * TICK_DIV_TB) @(posedge clk); // bombs in flight settle
		@(negedge clk);
		held = score;
		repeat (1000 * TICK_DIV_TB) @(posedge clk);
		@(negedge clk);
		expect_value("score", score, held);

		$display("Check summary: %0d testbench errors, %0d assertion failures, %0d timeouts",
			tb_errors, dut0.u_props.fail_count, timeouts);
		if ((tb_errors == 0) && (dut0.u_props.fail_count == 0) && (timeouts == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== kaboom.f ====
src/kaboom_pkg.sv
src/vga_timing.sv
src/player_motion.sv
src/bomb_drop.sv
src/pixel_color.sv
src/kaboom_top.sv
verification/kaboom_properties.sv
verification/kaboom_tb.sv

// ==== Makefile ====
# Verilator build and run of the kaboom testbench

VERILATOR ?= verilator
TOP       ?= kaboom_tb
FILELIST  ?= kaboom.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass message"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
